//--- mem_settings.svh
// scratch memory settings: default word width, memory depth and address width
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// word geometry
////////////////////////////////////////////////////////////////////////////

// width of one data word in bits
// it is not a multiple of 64, so the last lane is only half used
`define MEM_DATA_WIDTH 96

////////////////////////////////////////////////////////////////////////////
// address space
////////////////////////////////////////////////////////////////////////////

// number of words actually backed by storage
// this stays below the address range, so the upper addresses give an error
`define MEM_NUM_WORDS 200

// width of a word address as seen by the requester
`define MEM_ADDR_WIDTH 8

`endif

//--- mem_data_pkg.sv
// data package: vector types for words, byte enables, addresses and memory lanes
`include "mem_settings.svh"

package mem_data_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // requester side
  ////////////////////////////////////////////////////////////////////////////

  // one full data word as seen on the external port
  typedef logic [`MEM_DATA_WIDTH-1:0] word_t;

  // one enable per byte of a word, the last byte may be partial
  typedef logic [(`MEM_DATA_WIDTH+7)/8-1:0] be_t;

  // word address, wide enough to reach past the backed depth
  typedef logic [`MEM_ADDR_WIDTH-1:0] addr_t;

  ////////////////////////////////////////////////////////////////////////////
  // storage side
  ////////////////////////////////////////////////////////////////////////////

  // the memory is cut into lanes of 64 bits each
  typedef logic [63:0] lane_t;

  // eight byte enables cover one lane
  typedef logic [7:0] lane_be_t;

endpackage : mem_data_pkg

//--- mem_ctrl_pkg.sv
// control package: state encodings of the request and response handshake FSMs
package mem_ctrl_pkg;

  // request port FSM
  // idle waits for req, busy holds while the access is in flight,
  // release waits for the response side to finish the handshake
  typedef enum logic [1:0] {
    REQ_IDLE    = 2'b00,
    REQ_BUSY    = 2'b01,
    REQ_RELEASE = 2'b10
  } req_state_e;

  // response port FSM
  // idle waits for data, acked holds ack high until req drops,
  // wait_done lowers ack and tells the request port we are finished
  typedef enum logic [1:0] {
    RESP_IDLE      = 2'b00,
    RESP_ACKED     = 2'b01,
    RESP_WAIT_DONE = 2'b10
  } resp_state_e;

endpackage : mem_ctrl_pkg

//--- mem_lane_sram.sv
// lane memory: single-port 64-bit synchronous memory with byte writes and registered read
`timescale 1ns/10ps
`include "mem_settings.svh"

module mem_lane_sram #(
  parameter int DEPTH = `MEM_NUM_WORDS
) (
  input  logic                   clk_ci,
  input  logic                   rst_n_i,
  input  logic                   csel_i,
  input  logic                   wen_i,
  input  mem_data_pkg::lane_be_t ben_i,
  input  mem_data_pkg::lane_t    wdata_i,
  input  mem_data_pkg::addr_t    addr_i,
  output mem_data_pkg::lane_t    rdata_o
);

  import mem_data_pkg::*;

  // storage, contents are undefined until first written
  lane_t mem_q [DEPTH];

  ////////////////////////////////////////////////////////////////////////////
  // write and read
  ////////////////////////////////////////////////////////////////////////////

  // each enabled byte is written on its own, the others keep their value
  always_ff @(posedge clk_ci) begin : p_write
    if (csel_i && wen_i) begin
      for (int b = 0; b < $bits(lane_be_t); b++) begin
        if (ben_i[b]) begin
          mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // the read samples the word before the write above lands,
  // so a write access returns the old contents
  always_ff @(posedge clk_ci or negedge rst_n_i) begin : p_read
    if (!rst_n_i) begin
      rdata_o <= '0;
    end else if (csel_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // assertions
  ////////////////////////////////////////////////////////////////////////////

  // the address bus must be able to reach every word
  if (longint'(DEPTH) > (longint'(1) << $bits(addr_t))) begin : gen_depth_check
    $error("DEPTH does not fit into the address width");
  end

  // out-of-range accesses are filtered upstream in the request port
  a_addr_in_range : assert property (
    @(posedge clk_ci) disable iff (!rst_n_i) csel_i |-> (32'(addr_i) < DEPTH)
  ) else $error("lane memory selected with an address beyond its depth");

endmodule : mem_lane_sram

//--- mem_wide_sram.sv
// wide memory: aligns a word to 64-bit lanes and spreads it over lane memories
`timescale 1ns/10ps
`include "mem_settings.svh"

module mem_wide_sram #(
  parameter int DATA_WIDTH = `MEM_DATA_WIDTH,
  parameter int NUM_WORDS  = `MEM_NUM_WORDS
) (
  input  logic                clk_ci,
  input  logic                rst_n_i,
  input  logic                access_i,
  input  logic                we_i,
  input  mem_data_pkg::addr_t addr_i,
  input  mem_data_pkg::word_t wdata_i,
  input  mem_data_pkg::be_t   be_i,
  output mem_data_pkg::word_t rdata_o
);

  import mem_data_pkg::*;

  localparam int LANE_W     = $bits(lane_t);
  localparam int LANE_BE_W  = $bits(lane_be_t);
  localparam int NUM_LANES  = (DATA_WIDTH + LANE_W - 1) / LANE_W;
  localparam int BE_W       = (DATA_WIDTH + 7) / 8;

  logic [NUM_LANES*LANE_W-1:0]    wdata_aligned;
  logic [NUM_LANES*LANE_BE_W-1:0] be_aligned;
  logic [NUM_LANES*LANE_W-1:0]    rdata_aligned;

  // the port types come from the package, so the parameter has to agree
  if ($bits(word_t) != DATA_WIDTH) begin : gen_width_check
    $error("DATA_WIDTH does not match the word type of the data package");
  end

  // pad up to whole lanes
  // the padding enables stay zero, so unused bytes of the last lane never change
  always_comb begin : p_align
    wdata_aligned                 = '0;
    be_aligned                    = '0;
    wdata_aligned[DATA_WIDTH-1:0] = wdata_i;
    be_aligned[BE_W-1:0]          = be_i;
  end

  // drop the padding again on the way back
  assign rdata_o = rdata_aligned[DATA_WIDTH-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // one lane memory per 64 bits of the word
  ////////////////////////////////////////////////////////////////////////////

  for (genvar l = 0; l < NUM_LANES; l++) begin : gen_lane
    mem_lane_sram #(
      .DEPTH (NUM_WORDS)
    ) lane_inst (
      .clk_ci  (clk_ci),
      .rst_n_i (rst_n_i),
      .csel_i  (access_i),
      .wen_i   (we_i),
      .ben_i   (be_aligned[l*LANE_BE_W +: LANE_BE_W]),
      .wdata_i (wdata_aligned[l*LANE_W +: LANE_W]),
      .addr_i  (addr_i),
      .rdata_o (rdata_aligned[l*LANE_W +: LANE_W])
    );
  end

endmodule : mem_wide_sram

//--- mem_req_port.sv
// request port: captures a four-phase access, checks its range and issues one strobe
`timescale 1ns/10ps
`include "mem_settings.svh"

module mem_req_port #(
  parameter int NUM_WORDS = `MEM_NUM_WORDS
) (
  input  logic                clk_ci,
  input  logic                rst_n_i,
  input  logic                req_i,
  input  logic                we_i,
  input  mem_data_pkg::addr_t addr_i,
  input  mem_data_pkg::word_t wdata_i,
  input  mem_data_pkg::be_t   be_i,
  input  logic                done_i,
  output logic                access_o,
  output logic                we_o,
  output mem_data_pkg::addr_t addr_o,
  output mem_data_pkg::word_t wdata_o,
  output mem_data_pkg::be_t   be_o,
  output logic                range_err_o
);

  import mem_data_pkg::*;
  import mem_ctrl_pkg::*;

  req_state_e state_q;
  req_state_e state_d;
  logic       accept;

  // a request is taken either from idle or straight out of release,
  // in the same cycle done arrives, so back-to-back accesses keep
  // the fixed latency
  assign accept = req_i && ((state_q == REQ_IDLE) ||
                            ((state_q == REQ_RELEASE) && done_i));

  ////////////////////////////////////////////////////////////////////////////
  // handshake FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : p_next_state
    state_d = state_q;
    case (state_q)
      REQ_IDLE: begin
        if (req_i) begin
          state_d = REQ_BUSY;
        end
      end
      // the requester drops req only after it has seen ack
      REQ_BUSY: begin
        if (!req_i) begin
          state_d = REQ_RELEASE;
        end
      end
      REQ_RELEASE: begin
        if (done_i) begin
          state_d = req_i ? REQ_BUSY : REQ_IDLE;
        end
      end
      default: state_d = REQ_IDLE;
    endcase
  end

  always_ff @(posedge clk_ci or negedge rst_n_i) begin : p_state
    if (!rst_n_i) begin
      state_q     <= REQ_IDLE;
      access_o    <= 1'b0;
      range_err_o <= 1'b0;
    end else begin
      state_q  <= state_d;
      // strobe lasts exactly one cycle per accepted request
      access_o <= accept;
      if (accept) begin
        range_err_o <= (32'(addr_i) >= NUM_WORDS);
      end
    end
  end

  // operands are only meaningful while the strobe is high
  always_ff @(posedge clk_ci) begin : p_operands
    if (accept) begin
      we_o    <= we_i;
      addr_o  <= addr_i;
      wdata_o <= wdata_i;
      be_o    <= be_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // assertions
  ////////////////////////////////////////////////////////////////////////////

  // one access per handshake, so the strobe can never stretch
  a_single_strobe : assert property (
    @(posedge clk_ci) disable iff (!rst_n_i) access_o |=> !access_o
  ) else $error("access strobe high for two cycles");

endmodule : mem_req_port

//--- mem_resp_port.sv
// response port: returns read data or an error flag and completes the four-phase handshake
`timescale 1ns/10ps

module mem_resp_port (
  input  logic                clk_ci,
  input  logic                rst_n_i,
  input  logic                access_i,
  input  logic                range_err_i,
  input  mem_data_pkg::word_t rdata_i,
  input  logic                req_i,
  output logic                ack_o,
  output logic                err_o,
  output mem_data_pkg::word_t rdata_o,
  output logic                done_o
);

  import mem_data_pkg::*;
  import mem_ctrl_pkg::*;

  resp_state_e state_q;
  logic        access_q;
  logic        range_err_q;
  logic        load_q;

  ////////////////////////////////////////////////////////////////////////////
  // data path
  ////////////////////////////////////////////////////////////////////////////

  // the strobe is delayed by one cycle so it meets the memory output
  // and load_q then marks the cycle in which the response data is settled
  always_ff @(posedge clk_ci or negedge rst_n_i) begin : p_align
    if (!rst_n_i) begin
      access_q    <= 1'b0;
      range_err_q <= 1'b0;
      load_q      <= 1'b0;
      rdata_o     <= '0;
      err_o       <= 1'b0;
    end else begin
      access_q    <= access_i;
      range_err_q <= range_err_i;
      load_q      <= access_q;
      if (access_q) begin
        // the memory was not selected on a range error so its output is stale
        rdata_o <= range_err_q ? word_t'(0) : rdata_i;
        err_o   <= range_err_q;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // handshake FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_ci or negedge rst_n_i) begin : p_fsm
    if (!rst_n_i) begin
      state_q <= RESP_IDLE;
      ack_o   <= 1'b0;
      done_o  <= 1'b0;
    end else begin
      // done is a single-cycle pulse
      done_o <= 1'b0;
      case (state_q)
        RESP_IDLE: begin
          if (load_q) begin
            ack_o   <= 1'b1;
            state_q <= RESP_ACKED;
          end
        end
        // hold ack until the requester has taken the data
        RESP_ACKED: begin
          if (!req_i) begin
            state_q <= RESP_WAIT_DONE;
          end
        end
        // ack falls here and the request port is released in the same edge
        RESP_WAIT_DONE: begin
          ack_o   <= 1'b0;
          done_o  <= 1'b1;
          state_q <= RESP_IDLE;
        end
        default: state_q <= RESP_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // assertions
  ////////////////////////////////////////////////////////////////////////////

  // ack may only rise while req is still held at the edge that raises it
  a_ack_needs_req : assert property (
    @(posedge clk_ci) disable iff (!rst_n_i) $rose(ack_o) |-> $past(req_i)
  ) else $error("ack raised without a pending request");

endmodule : mem_resp_port

//--- mem_subsys_top.sv
// scratch memory subsystem top: request port, wide memory and response port in a chain
`timescale 1ns/10ps
`include "mem_settings.svh"

module mem_subsys_top #(
  parameter int DATA_WIDTH = `MEM_DATA_WIDTH,
  parameter int NUM_WORDS  = `MEM_NUM_WORDS
) (
  input  logic                clk_ci,
  input  logic                rst_n_i,
  input  logic                req_i,
  input  logic                we_i,
  input  mem_data_pkg::addr_t addr_i,
  input  mem_data_pkg::word_t wdata_i,
  input  mem_data_pkg::be_t   be_i,
  output logic                ack_o,
  output logic                err_o,
  output mem_data_pkg::word_t rdata_o
);

  import mem_data_pkg::*;

  // request port to memory and response port
  logic  access;
  logic  mem_we;
  addr_t mem_addr;
  word_t mem_wdata;
  be_t   mem_be;
  logic  range_err;
  // memory to response port, and the handshake return
  word_t mem_rdata;
  logic  done;

  mem_req_port #(
    .NUM_WORDS (NUM_WORDS)
  ) req_port_inst (
    .clk_ci      (clk_ci),
    .rst_n_i     (rst_n_i),
    .req_i       (req_i),
    .we_i        (we_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .be_i        (be_i),
    .done_i      (done),
    .access_o    (access),
    .we_o        (mem_we),
    .addr_o      (mem_addr),
    .wdata_o     (mem_wdata),
    .be_o        (mem_be),
    .range_err_o (range_err)
  );

  // a bad address never selects the memory, so error writes change nothing
  mem_wide_sram #(
    .DATA_WIDTH (DATA_WIDTH),
    .NUM_WORDS  (NUM_WORDS)
  ) wide_sram_inst (
    .clk_ci   (clk_ci),
    .rst_n_i  (rst_n_i),
    .access_i (access & ~range_err),
    .we_i     (mem_we),
    .addr_i   (mem_addr),
    .wdata_i  (mem_wdata),
    .be_i     (mem_be),
    .rdata_o  (mem_rdata)
  );

  mem_resp_port resp_port_inst (
    .clk_ci      (clk_ci),
    .rst_n_i     (rst_n_i),
    .access_i    (access),
    .range_err_i (range_err),
    .rdata_i     (mem_rdata),
    .req_i       (req_i),
    .ack_o       (ack_o),
    .err_o       (err_o),
    .rdata_o     (rdata_o),
    .done_o      (done)
  );

endmodule : mem_subsys_top

//--- mem_checker.sv
// testbench checker: byte-wise reference model of the memory and handshake monitor
`timescale 1ns/10ps
`include "mem_settings.svh"

module mem_checker (
  input  logic                clk_ci,
  input  logic                rst_n_i,
  input  logic                req_i,
  input  logic                we_i,
  input  mem_data_pkg::addr_t addr_i,
  input  mem_data_pkg::word_t wdata_i,
  input  mem_data_pkg::be_t   be_i,
  input  logic                ack_i,
  input  logic                err_i,
  input  mem_data_pkg::word_t rdata_i,
  input  logic                exp_valid_i,
  input  mem_data_pkg::word_t exp_rdata_i,
  input  logic                exp_err_i,
  output int                  data_errors_o,
  output int                  proto_errors_o,
  output int                  completed_o
);

  import mem_data_pkg::*;

  localparam int NUM_WORDS = `MEM_NUM_WORDS;
  localparam int BE_W      = $bits(be_t);

  // unwritten bytes stay unknown and are skipped in the compare
  logic [7:0] model_q [NUM_WORDS][BE_W];

  // operands captured when the request opens
  logic  op_we;
  addr_t op_addr;
  word_t op_wdata;
  be_t   op_be;
  logic  op_exp_valid;
  word_t op_exp_rdata;
  logic  op_exp_err;
  // handshake tracking
  logic  req_q;
  logic  ack_q;
  logic  pend;
  logic  releasing;
  logic  seen_req;
  int    lat;
  int    rel;

  ////////////////////////////////////////////////////////////////////////////
  // response compare
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_response();
    logic  bad_err;
    logic  range_err;
    logic  model_ok;
    word_t model_word;
    range_err  = int'(op_addr) >= NUM_WORDS;
    model_ok   = 1'b1;
    model_word = '0;
    bad_err    = (err_i !== range_err);
    if (bad_err) begin
      data_errors_o++;
      $display("FAIL %0d ns: err is %b for word %0d, expected %b", $time, err_i, op_addr,
               range_err);
    end
    if (range_err) begin
      if (rdata_i !== '0) begin
        data_errors_o++;
        $display("FAIL %0d ns: error access returned data %h", $time, rdata_i);
      end
    end else if (!op_we) begin
      for (int b = 0; b < BE_W; b++) begin
        model_word[b*8 +: 8] = model_q[op_addr][b];
        if (!$isunknown(model_q[op_addr][b]) && rdata_i[b*8 +: 8] !== model_q[op_addr][b]) begin
          model_ok = 1'b0;
        end
      end
      if (!model_ok) begin
        data_errors_o++;
        $display("FAIL %0d ns: read of word %0d returned %h, model holds %h", $time,
                 op_addr, rdata_i, model_word);
      end
    end else begin
      // only enabled bytes of an in-range write reach the model
      for (int b = 0; b < BE_W; b++) begin
        if (op_be[b]) begin
          model_q[op_addr][b] = op_wdata[b*8 +: 8];
        end
      end
    end
    // table entries also carry hand-worked expected values
    if (op_exp_valid && (err_i !== op_exp_err ||
        ((!op_we || op_exp_err) && rdata_i !== op_exp_rdata))) begin
      data_errors_o++;
      $display("FAIL %0d ns: word %0d gave data %h err %b, table expects %h err %b", $time,
               op_addr, rdata_i, err_i, op_exp_rdata, op_exp_err);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // handshake monitor
  ////////////////////////////////////////////////////////////////////////////

  // values are sampled before the edge updates land, so an ack raised at
  // edge k+3 is first seen at k+4, and one dropped at j+1 is seen at j+2
  always @(posedge clk_ci) begin : p_watch
    if (!rst_n_i) begin
      data_errors_o  = 0;
      proto_errors_o = 0;
      completed_o    = 0;
      req_q          = 1'b0;
      ack_q          = 1'b0;
      pend           = 1'b0;
      releasing      = 1'b0;
      seen_req       = 1'b0;
    end else begin
      if (!seen_req && (ack_i !== 1'b0 || err_i !== 1'b0 || rdata_i !== '0)) begin
        data_errors_o++;
        $display("FAIL %0d ns: outputs not at rest after reset", $time);
      end
      if (pend) begin
        lat++;
        rel++;
      end
      if (!ack_i && ack_q) begin
        if (!releasing || rel != 2) begin
          proto_errors_o++;
          $display("protocol error at %0d ns: ack fell at the wrong time", $time);
        end
        pend      = 1'b0;
        releasing = 1'b0;
      end
      if (ack_i && !ack_q) begin
        if (!pend) begin
          proto_errors_o++;
          $display("protocol error at %0d ns: ack rose without a request", $time);
        end else begin
          if (lat != 4) begin
            proto_errors_o++;
            $display("protocol error at %0d ns: ack rose %0d cycles after req, not 3",
                     $time, lat - 1);
          end
          check_response();
          completed_o++;
        end
      end
      if (!req_i && req_q && pend) begin
        releasing = 1'b1;
        rel       = 0;
      end
      if (req_i && !req_q) begin
        if (pend) begin
          proto_errors_o++;
          $display("protocol error at %0d ns: new request before ack fell", $time);
        end
        op_we        = we_i;
        op_addr      = addr_i;
        op_wdata     = wdata_i;
        op_be        = be_i;
        op_exp_valid = exp_valid_i;
        op_exp_rdata = exp_rdata_i;
        op_exp_err   = exp_err_i;
        pend         = 1'b1;
        seen_req     = 1'b1;
        lat          = 0;
      end
      req_q = req_i;
      ack_q = ack_i;
    end
  end

endmodule : mem_checker

//--- tb_mem_subsys.sv
// testbench top for the scratch memory subsystem: clock, reset, stimulus table and report
`timescale 1ns/10ps
`include "mem_settings.svh"

module tb_mem_subsys;

  import mem_data_pkg::*;

  localparam int NUM_WORDS  = `MEM_NUM_WORDS;
  localparam int NUM_RANDOM = 40;
  localparam int ACK_LIMIT  = 8;

  logic  clk_ci;
  logic  rst_n;
  logic  req;
  logic  we;
  addr_t addr;
  word_t wdata;
  be_t   be;
  logic  ack;
  logic  err;
  word_t rdata;
  // expected values of the current table entry, passed on to the checker
  logic  exp_valid;
  word_t exp_rdata;
  logic  exp_err;
  int    data_errors;
  int    proto_errors;
  int    completed;
  int    driver_errors;
  int    issued;
  logic  table_ready;

  // stimulus table, one access per index
  logic  tab_we [$];
  addr_t tab_addr [$];
  word_t tab_wdata [$];
  be_t   tab_be [$];
  word_t tab_rdata [$];
  logic  tab_err [$];

  // words that hold a full write, the only ones the random phase reads
  bit    written [NUM_WORDS];
  addr_t written_q [$];

  initial begin : p_clock
    clk_ci = 1'b0;
    forever #20 clk_ci = ~clk_ci;
  end

  mem_subsys_top mem_subsys_top_inst (
    .clk_ci  (clk_ci),
    .rst_n_i (rst_n),
    .req_i   (req),
    .we_i    (we),
    .addr_i  (addr),
    .wdata_i (wdata),
    .be_i    (be),
    .ack_o   (ack),
    .err_o   (err),
    .rdata_o (rdata)
  );

  mem_checker checker_inst (
    .clk_ci (clk_ci), .rst_n_i (rst_n), .req_i (req), .we_i (we), .addr_i (addr),
    .wdata_i (wdata), .be_i (be), .ack_i (ack), .err_i (err), .rdata_i (rdata),
    .exp_valid_i (exp_valid), .exp_rdata_i (exp_rdata), .exp_err_i (exp_err),
    .data_errors_o (data_errors), .proto_errors_o (proto_errors), .completed_o (completed)
  );

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic add_entry(input logic w, input int a, input word_t d, input be_t e,
                           input word_t r, input logic x);
    tab_we.push_back(w);
    tab_addr.push_back(addr_t'(a));
    tab_wdata.push_back(d);
    tab_be.push_back(e);
    tab_rdata.push_back(r);
    tab_err.push_back(x);
  endtask

  // read data of a write is the old word, so only reads and errors carry expected data
  task automatic build_table();
    add_entry(1'b1, 5, 96'h0123_4567_89ab_cdef_fedc_ba98, '1, '0, 1'b0);
    add_entry(1'b0, 5, '0, '0, 96'h0123_4567_89ab_cdef_fedc_ba98, 1'b0);
    // bytes 0, 4 and 11, the last one sits in the upper lane
    add_entry(1'b1, 5, 96'h1122_3344_5566_7788_99aa_bbcc, 12'h811, '0, 1'b0);
    add_entry(1'b0, 5, '0, '0, 96'h1123_4567_89ab_cd88_fedc_bacc, 1'b0);
    add_entry(1'b1, 199, 96'hdead_beef_cafe_f00d_1234_5678, '1, '0, 1'b0);
    add_entry(1'b1, 199, 96'h0bad_c0de_0000_0000_0000_0000, 12'hf00, '0, 1'b0);
    add_entry(1'b0, 199, '0, '0, 96'h0bad_c0de_cafe_f00d_1234_5678, 1'b0);
    // first address past the backed depth, then the top of the address range
    add_entry(1'b1, 200, '1, '1, '0, 1'b1);
    add_entry(1'b0, 255, '0, '0, '0, 1'b1);
    add_entry(1'b0, 199, '0, '0, 96'h0bad_c0de_cafe_f00d_1234_5678, 1'b0);
    // a write without enabled bytes leaves the word alone
    add_entry(1'b1, 5, '1, '0, '0, 1'b0);
    add_entry(1'b0, 5, '0, '0, 96'h1123_4567_89ab_cd88_fedc_bacc, 1'b0);
    add_entry(1'b1, 0, 96'h5a5a_a5a5_0f0f_f0f0_3c3c_c3c3, '1, '0, 1'b0);
    add_entry(1'b0, 0, '0, '0, 96'h5a5a_a5a5_0f0f_f0f0_3c3c_c3c3, 1'b0);
  endtask

  // called on a falling edge, returns on the falling edge where ack is seen low again
  task automatic do_access(input logic w, input addr_t a, input word_t d, input be_t e,
                           input logic ev, input word_t er, input logic ee);
    int cnt;
    we        = w;
    addr      = a;
    wdata     = d;
    be        = e;
    exp_valid = ev;
    exp_rdata = er;
    exp_err   = ee;
    req       = 1'b1;
    issued++;
    cnt = 0;
    do begin
      @(negedge clk_ci);
      cnt++;
    end while (!ack && cnt < ACK_LIMIT);
    if (!ack) begin
      driver_errors++;
      $display("no ack from the DUT within %0d cycles for word %0d", ACK_LIMIT, a);
    end
    req = 1'b0;
    cnt = 0;
    do begin
      @(negedge clk_ci);
      cnt++;
    end while (ack && cnt < ACK_LIMIT);
    if (ack) begin
      driver_errors++;
      $display("ack stayed high %0d cycles after req dropped for word %0d", ACK_LIMIT, a);
    end
    if (w && int'(a) < NUM_WORDS && e == '1 && !written[a]) begin
      written[a] = 1'b1;
      written_q.push_back(a);
    end
  endtask

  // a new word gets a full write first, later writes use random enables
  task automatic random_access();
    logic  w;
    addr_t a;
    word_t d;
    be_t   e;
    w = (written_q.size() == 0) || ($urandom_range(1, 0) == 1);
    d = '0;
    e = '0;
    if (w) begin
      a = addr_t'($urandom_range(NUM_WORDS - 1, 0));
      d = word_t'({$urandom, $urandom, $urandom});
      e = written[a] ? be_t'($urandom) : '1;
    end else begin
      a = written_q[$urandom_range(written_q.size() - 1, 0)];
    end
    do_access(w, a, d, e, 1'b0, '0, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // run control
  ////////////////////////////////////////////////////////////////////////////

  initial begin : p_main
    rst_n         = 1'b0;
    req           = 1'b0;
    we            = 1'b0;
    addr          = '0;
    wdata         = '0;
    be            = '0;
    exp_valid     = 1'b0;
    exp_rdata     = '0;
    exp_err       = 1'b0;
    driver_errors = 0;
    issued        = 0;
    table_ready   = 1'b0;
    void'($urandom(18851));
    build_table();
    table_ready = 1'b1;
    repeat (3) @(negedge clk_ci);
    rst_n = 1'b1;
    // a few idle cycles so the checker sees the outputs at rest
    repeat (4) @(negedge clk_ci);
    for (int i = 0; i < tab_we.size(); i++) begin
      do_access(tab_we[i], tab_addr[i], tab_wdata[i], tab_be[i], 1'b1, tab_rdata[i],
                tab_err[i]);
    end
    repeat (NUM_RANDOM) random_access();
    repeat (2) @(negedge clk_ci);
    if (completed != issued) begin
      driver_errors++;
      $display("only %0d of %0d accesses completed", completed, issued);
    end
    $display("accesses %0d, data errors %0d, protocol errors %0d, driver errors %0d",
             issued, data_errors, proto_errors, driver_errors);
    if (data_errors + proto_errors + driver_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // ten cycles per access is well above the handshake length, fifty more cover reset
  initial begin : p_watchdog
    int limit;
    wait (table_ready);
    limit = (tab_we.size() + NUM_RANDOM) * 10 + 50;
    repeat (limit) @(posedge clk_ci);
    $display("timeout: the run did not end within %0d cycles", limit);
    $display("Simulation FAILED");
    $finish;
  end

endmodule : tb_mem_subsys

//--- tb.f
+incdir+.
mem_data_pkg.sv
mem_ctrl_pkg.sv
mem_lane_sram.sv
mem_wide_sram.sv
mem_req_port.sv
mem_resp_port.sv
mem_subsys_top.sv
mem_checker.sv
tb_mem_subsys.sv
